/* Makefile */
# Verilator build and run of the tile glue testbench

VERILATOR ?= verilator
TOP       ?= tb_tile_glue
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* src/hpm_counters.sv */
`timescale 1ns/1ps
`include "tile_config.svh"

module hpm_counters (
    input  logic                 CLK,
    input  logic                 RST,
    input  tile_pkg::apb_req_t   apb_i,
    input  logic                 refill_evt_i,
    input  logic                 l2_hit_evt_i,
    input  logic                 ptw_req_evt_i,
    input  logic                 ptw_amo_evt_i,
    output tile_pkg::apb_rsp_t   apb_o
);

    logic [63:0]              cnt_q [`TILE_HPM_N];
    logic [`TILE_HPM_N-1:0]   evt;
    logic                     access;
    logic                     addr_err;
    logic                     wr_en;
    logic [`TILE_APB_AW-1:3]  sel_idx;              // Counter number
    logic                     sel_hi;               // Upper 32 bits
    logic [63:0]              rd_cnt;

    // ------------------------------------------------------------------------
    // Event map
    // ------------------------------------------------------------------------
    assign evt[`TILE_HPM_CYCLES]  = 1'b1;
    assign evt[`TILE_HPM_REFILL]  = refill_evt_i;
    assign evt[`TILE_HPM_L2HIT]   = l2_hit_evt_i;
    assign evt[`TILE_HPM_PTW_REQ] = ptw_req_evt_i;
    assign evt[`TILE_HPM_PTW_AMO] = ptw_amo_evt_i;

    // ------------------------------------------------------------------------
    // APB decode
    // ------------------------------------------------------------------------
    assign access  = apb_i.psel && apb_i.penable;   // Access phase, no wait states
    assign sel_idx = apb_i.paddr[`TILE_APB_AW-1:3];
    assign sel_hi  = apb_i.paddr[2];

    // Misaligned or past the last counter
    assign addr_err = (apb_i.paddr[1:0] != 2'b00) ||
                      (apb_i.paddr >= `TILE_APB_AW'(`TILE_HPM_N * 8));

    assign wr_en = access && apb_i.pwrite && !addr_err;

    // Read mux over the counter bank
    always_comb begin
        rd_cnt = '0;
        for (int k = 0; k < `TILE_HPM_N; k++) begin
            if (int'(sel_idx) == k) rd_cnt = cnt_q[k];
        end
    end

    assign apb_o.pready  = apb_i.psel;
    assign apb_o.prdata  = (apb_i.psel && !addr_err) ?
                           (sel_hi ? rd_cnt[63:32] : rd_cnt[31:0]) : 32'd0;
    assign apb_o.pslverr = access && addr_err;

    // ------------------------------------------------------------------------
    // Counter bank
    // ------------------------------------------------------------------------
    for (genvar g = 0; g < `TILE_HPM_N; g++) begin : g_cnt
        always_ff @(posedge CLK or negedge RST) begin
            if (!RST) begin
                cnt_q[g] <= '0;
            end else if (wr_en && int'(sel_idx) == g) begin
                // Write replaces one half, event of this cycle is lost
                if (sel_hi) begin
                    cnt_q[g][63:32] <= apb_i.pwdata;
                end else begin
                    cnt_q[g][31:0] <= apb_i.pwdata;
                end
            end else begin
                cnt_q[g] <= cnt_q[g] + 64'(evt[g]);
            end
        end
    end

    // Requester must hold psel through the access phase
    a_penable_psel: assert property (@(posedge CLK) disable iff (!RST)
        apb_i.penable |-> apb_i.psel);

endmodule

/* src/l2_refill_bridge.sv */
`timescale 1ns/1ps
`include "tile_config.svh"

module l2_refill_bridge (
    input  logic                   CLK,
    input  logic                   RST,
    input  tile_pkg::fill_req_t    fill_req_i,
    input  logic                   acquire_ready_i,
    input  tile_pkg::l2_grant_t    grant_i,
    input  logic                   l2_hit_i,        // Valid with the grant beat
    output logic                   fill_ready_o,
    output tile_pkg::fill_resp_t   fill_resp_o,
    output tile_pkg::l2_acquire_t  acquire_o,
    output logic                   refill_evt_o,
    output logic                   l2_hit_evt_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACQ,                                     // Acquire pending
        ST_GRANT                                    // Collecting beats
    } state_e;

    state_e                          state_q;
    logic [`TILE_BLOCK_ADDR_W-1:0]   blk_addr_q;
    logic [$clog2(`TILE_BEATS)-1:0]  beat_exp_q;    // Next beat expected
    logic                            beat_fire;
    logic                            last_beat;
    logic                            resp_valid_q;
    logic                            resp_ack_q;
    logic                            resp_hit_q;
    logic [$clog2(`TILE_BEATS)-1:0]  resp_beat_q;
    logic [`TILE_BEAT_W-1:0]         resp_data_q;

    assign beat_fire = (state_q == ST_GRANT) && grant_i.valid;
    assign last_beat = int'(grant_i.beat) == `TILE_BEATS - 1;

    // ------------------------------------------------------------------------
    // Control FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            state_q      <= ST_IDLE;
            beat_exp_q   <= '0;
            resp_valid_q <= 1'b0;
            resp_ack_q   <= 1'b0;
            resp_hit_q   <= 1'b0;
        end else begin
            resp_valid_q <= beat_fire;
            resp_ack_q   <= beat_fire && last_beat;
            resp_hit_q   <= beat_fire && last_beat && l2_hit_i;  // Hit sampled on last beat
            case (state_q)
                ST_IDLE: begin
                    if (fill_req_i.valid) state_q <= ST_ACQ;
                end
                ST_ACQ: begin
                    if (acquire_ready_i) begin
                        state_q    <= ST_GRANT;
                        beat_exp_q <= '0;
                    end
                end
                ST_GRANT: begin
                    if (beat_fire) beat_exp_q <= beat_exp_q + 1'b1;
                    if (resp_ack_q) state_q <= ST_IDLE;       // Free after ack cycle
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Line address and beat payload
    always_ff @(posedge CLK) begin
        if (fill_ready_o && fill_req_i.valid) blk_addr_q <= fill_req_i.block_addr;
        if (beat_fire) begin
            resp_beat_q <= grant_i.beat;
            resp_data_q <= grant_i.data;
        end
    end

    assign fill_ready_o         = state_q == ST_IDLE;
    assign acquire_o.valid      = state_q == ST_ACQ;
    assign acquire_o.block_addr = blk_addr_q;
    assign fill_resp_o.valid    = resp_valid_q;
    assign fill_resp_o.beat     = resp_beat_q;
    assign fill_resp_o.data     = resp_data_q;
    assign fill_resp_o.ack      = resp_ack_q;
    assign refill_evt_o         = resp_ack_q;
    assign l2_hit_evt_o         = resp_hit_q;

    // ------------------------------------------------------------------------
    // L2 protocol checks
    // ------------------------------------------------------------------------
    a_grant_in_state: assert property (@(posedge CLK) disable iff (!RST)
        grant_i.valid |-> state_q == ST_GRANT);
    a_beat_order: assert property (@(posedge CLK) disable iff (!RST)
        grant_i.valid |-> grant_i.beat == beat_exp_q);
    a_acq_stable: assert property (@(posedge CLK) disable iff (!RST)
        acquire_o.valid && !acquire_ready_i |=>
            acquire_o.valid && $stable(acquire_o.block_addr));

endmodule

/* src/ptw_dmem_adapter.sv */
`timescale 1ns/1ps
`include "tile_config.svh"

module ptw_dmem_adapter (
    input  logic                   CLK,
    input  logic                   RST,
    input  tile_pkg::ptw_req_t     ptw_req_i,
    input  logic                   dcache_ready_i,
    input  tile_pkg::dcache_rsp_t  dcache_rsp_i,
    output logic                   ptw_ready_o,
    output tile_pkg::ptw_resp_t    ptw_resp_o,
    output tile_pkg::dcache_req_t  dcache_req_o,
    output logic                   req_evt_o,
    output logic                   amo_evt_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,                                     // Request waits for cache ready
        ST_WAIT                                     // Response outstanding
    } state_e;

    state_e                  state_q;
    logic                    is_amo;
    logic                    req_fire;
    tile_pkg::dcache_req_t   req_q;                 // Valid field unused here
    logic                    resp_valid_q;
    logic [`TILE_XLEN-1:0]   resp_data_q;

    // AMO-OR sets every byte, anything else is a plain load
    assign is_amo   = ptw_req_i.cmd == `TILE_CMD_AMO_OR;
    assign req_fire = (state_q == ST_REQ) && dcache_ready_i;

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            state_q      <= ST_IDLE;
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= (state_q == ST_WAIT) && dcache_rsp_i.valid;   // One cycle pulse
            case (state_q)
                ST_IDLE:  if (ptw_req_i.valid) state_q <= ST_REQ;
                ST_REQ:   if (dcache_ready_i) state_q <= ST_WAIT;
                ST_WAIT:  if (dcache_rsp_i.valid) state_q <= ST_IDLE;
                default:  state_q <= ST_IDLE;
            endcase
        end
    end

    // Translated request and returned data
    always_ff @(posedge CLK) begin
        if (ptw_ready_o && ptw_req_i.valid) begin
            req_q.valid <= 1'b1;
            req_q.addr  <= ptw_req_i.addr;
            req_q.wdata <= ptw_req_i.data;
            req_q.op    <= is_amo ? tile_pkg::DCACHE_AMO_OR : tile_pkg::DCACHE_LOAD;
            req_q.be    <= is_amo ? '1 : '0;
            req_q.size  <= ptw_req_i.size;
        end
        if (dcache_rsp_i.valid) resp_data_q <= dcache_rsp_i.rdata;
    end

    assign ptw_ready_o = state_q == ST_IDLE;

    always_comb begin
        dcache_req_o       = req_q;
        dcache_req_o.valid = state_q == ST_REQ;
    end

    assign ptw_resp_o.valid = resp_valid_q;
    assign ptw_resp_o.data  = resp_data_q;
    assign req_evt_o        = req_fire;
    assign amo_evt_o        = req_fire && (req_q.op == tile_pkg::DCACHE_AMO_OR);

    // ------------------------------------------------------------------------
    // Cache port checks
    // ------------------------------------------------------------------------
    a_rsp_expected: assert property (@(posedge CLK) disable iff (!RST)
        dcache_rsp_i.valid |-> state_q == ST_WAIT);
    a_req_stable: assert property (@(posedge CLK) disable iff (!RST)
        dcache_req_o.valid && !dcache_ready_i |=> $stable(dcache_req_o));

endmodule

/* src/tile_config.svh */
`ifndef TILE_CONFIG_SVH
`define TILE_CONFIG_SVH

// ------------------------------------------------------------------------
// Memory side widths
// ------------------------------------------------------------------------
`define TILE_PADDR_W        40          // Physical address
`define TILE_BLOCK_ADDR_W   34          // Line block address, 64 byte lines
`define TILE_BEAT_W         128         // One L2 grant beat
`define TILE_BEATS          4           // Beats per line
`define TILE_XLEN           64          // Walker data word

// Walker command encoding
`define TILE_CMD_W          5
`define TILE_CMD_AMO_OR     5'b01010    // Atomic OR, used for A/D bit updates

// ------------------------------------------------------------------------
// Performance counter map
// ------------------------------------------------------------------------
`define TILE_APB_AW         8
`define TILE_HPM_N          5
`define TILE_HPM_CYCLES     0           // Free running
`define TILE_HPM_REFILL     1           // Icache line refills
`define TILE_HPM_L2HIT      2           // Refills that hit in L2
`define TILE_HPM_PTW_REQ    3           // Walker requests to dcache
`define TILE_HPM_PTW_AMO    4           // Walker AMO-OR requests

`endif

/* src/tile_glue_top.sv */
`timescale 1ns/1ps

module tile_glue_top (
    input  logic                   CLK,
    input  logic                   RST,

    // ------------------------------------------------------------------------
    // Icache refill and L2
    // ------------------------------------------------------------------------
    input  tile_pkg::fill_req_t    fill_req_i,
    output logic                   fill_ready_o,
    output tile_pkg::fill_resp_t   fill_resp_o,
    output tile_pkg::l2_acquire_t  acquire_o,
    input  logic                   acquire_ready_i,
    input  tile_pkg::l2_grant_t    grant_i,
    input  logic                   l2_hit_i,        // L2 hit flag for PMU

    // ------------------------------------------------------------------------
    // Page table walker and dcache
    // ------------------------------------------------------------------------
    input  tile_pkg::ptw_req_t     ptw_req_i,
    output logic                   ptw_ready_o,
    output tile_pkg::ptw_resp_t    ptw_resp_o,
    output tile_pkg::dcache_req_t  dcache_req_o,
    input  logic                   dcache_ready_i,
    input  tile_pkg::dcache_rsp_t  dcache_rsp_i,

    // Counter access
    input  tile_pkg::apb_req_t     apb_i,
    output tile_pkg::apb_rsp_t     apb_o
);

    // Event pulses into the counters
    logic refill_evt;
    logic l2_hit_evt;
    logic ptw_req_evt;
    logic ptw_amo_evt;

    l2_refill_bridge u_refill (
        .CLK             (CLK),
        .RST             (RST),
        .fill_req_i      (fill_req_i),
        .acquire_ready_i (acquire_ready_i),
        .grant_i         (grant_i),
        .l2_hit_i        (l2_hit_i),
        .fill_ready_o    (fill_ready_o),
        .fill_resp_o     (fill_resp_o),
        .acquire_o       (acquire_o),
        .refill_evt_o    (refill_evt),
        .l2_hit_evt_o    (l2_hit_evt)
    );

    ptw_dmem_adapter u_ptw_dmem (
        .CLK            (CLK),
        .RST            (RST),
        .ptw_req_i      (ptw_req_i),
        .dcache_ready_i (dcache_ready_i),
        .dcache_rsp_i   (dcache_rsp_i),
        .ptw_ready_o    (ptw_ready_o),
        .ptw_resp_o     (ptw_resp_o),
        .dcache_req_o   (dcache_req_o),
        .req_evt_o      (ptw_req_evt),
        .amo_evt_o      (ptw_amo_evt)
    );

    hpm_counters u_hpm (
        .CLK           (CLK),
        .RST           (RST),
        .apb_i         (apb_i),
        .refill_evt_i  (refill_evt),
        .l2_hit_evt_i  (l2_hit_evt),
        .ptw_req_evt_i (ptw_req_evt),
        .ptw_amo_evt_i (ptw_amo_evt),
        .apb_o         (apb_o)
    );

endmodule

/* src/tile_pkg.sv */
`include "tile_config.svh"

package tile_pkg;

    // ------------------------------------------------------------------------
    // Icache refill and L2 channels
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic                             valid;
        logic [`TILE_BLOCK_ADDR_W-1:0]    block_addr;   // Line to fetch
    } fill_req_t;

    typedef struct packed {
        logic                             valid;
        logic [$clog2(`TILE_BEATS)-1:0]   beat;         // Beat inside the line
        logic [`TILE_BEAT_W-1:0]          data;
        logic                             ack;          // Last beat of the line
    } fill_resp_t;

    typedef struct packed {
        logic                             valid;
        logic [`TILE_BLOCK_ADDR_W-1:0]    block_addr;
    } l2_acquire_t;

    typedef struct packed {
        logic                             valid;
        logic [$clog2(`TILE_BEATS)-1:0]   beat;
        logic [`TILE_BEAT_W-1:0]          data;
    } l2_grant_t;

    // ------------------------------------------------------------------------
    // Walker and data cache port
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic                             valid;
        logic [`TILE_PADDR_W-1:0]         addr;
        logic [`TILE_XLEN-1:0]            data;
        logic [`TILE_CMD_W-1:0]           cmd;
        logic [1:0]                       size;         // log2 of bytes
    } ptw_req_t;

    typedef struct packed {
        logic                             valid;
        logic [`TILE_XLEN-1:0]            data;
    } ptw_resp_t;

    typedef enum logic {
        DCACHE_LOAD   = 1'b0,
        DCACHE_AMO_OR = 1'b1
    } dcache_op_e;

    typedef struct packed {
        logic                             valid;
        logic [`TILE_PADDR_W-1:0]         addr;
        logic [`TILE_XLEN-1:0]            wdata;
        dcache_op_e                       op;
        logic [`TILE_XLEN/8-1:0]          be;           // Byte enables
        logic [1:0]                       size;
    } dcache_req_t;

    typedef struct packed {
        logic                             valid;
        logic [`TILE_XLEN-1:0]            rdata;
    } dcache_rsp_t;

    // APB, counter access only
    typedef struct packed {
        logic                             psel;
        logic                             penable;
        logic                             pwrite;
        logic [`TILE_APB_AW-1:0]          paddr;
        logic [31:0]                      pwdata;
    } apb_req_t;

    typedef struct packed {
        logic                             pready;
        logic [31:0]                      prdata;
        logic                             pslverr;
    } apb_rsp_t;

endpackage

/* tests/tb_tile_glue_tasks.svh */
`ifndef TB_TILE_GLUE_TASKS_SVH
`define TB_TILE_GLUE_TASKS_SVH

// ------------------------------------------------------------------------
// Random numbers and checking
// ------------------------------------------------------------------------
function automatic logic [31:0] next_rand();
    rng_q ^= rng_q << 13;                       // xorshift32
    rng_q ^= rng_q >> 17;
    rng_q ^= rng_q << 5;
    return rng_q;
endfunction

task automatic check_eq(input logic [127:0] got, input logic [127:0] exp, input string what);
    if (got !== exp) begin
        $display("** Error at %0d ns: %s, got %0h expected %0h", $time, what, got, exp);
        $display("Simulation failed");
        $fatal(1, "mismatch on %s", what);
    end
endtask

task automatic timeout_fail(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Simulation failed");
    $fatal(1, "timeout");
endtask

// One APB transfer, setup then access phase
task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                        output logic [31:0] rdata, output logic err);
    @(negedge CLK);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge CLK);
    apb_req.penable = 1'b1;
    #1;                                         // Let read mux settle
    check_eq(128'(apb_rsp.pready), 128'(1), "pready in access phase");
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(negedge CLK);
    apb_req = '0;
endtask

task automatic read_counter(input int idx, input int exp_cnt, input string what);
    logic [31:0] lo;
    logic [31:0] hi;
    logic        err_lo;
    logic        err_hi;
    apb_xfer(1'b0, 8'(idx * 8), 32'd0, lo, err_lo);
    apb_xfer(1'b0, 8'(idx * 8 + 4), 32'd0, hi, err_hi);
    check_eq(128'({err_hi, err_lo}), 128'(0), {what, " pslverr"});
    check_eq(128'({hi, lo}), 128'(exp_cnt), what);
endtask

// ------------------------------------------------------------------------
// Request drivers and timed waits
// ------------------------------------------------------------------------
task automatic issue_fill();
    int          t;
    logic [63:0] r64;
    t   = 0;
    r64 = {next_rand(), next_rand()};
    repeat (r64[41:40]) @(negedge CLK);        // Random gap
    @(negedge CLK);
    while (!fill_ready) begin
        t++;
        if (t > 200) timeout_fail("fill_ready");
        @(negedge CLK);
    end
    exp_blk             = r64[33:0];
    fill_req.valid      = 1'b1;
    fill_req.block_addr = exp_blk;
    fills_sent++;
    @(negedge CLK);
    fill_req.valid = 1'b0;                      // Accepted on the last edge
endtask

task automatic issue_ptw();
    int                 t;
    logic [31:0]        r;
    logic [63:0]        r64;
    tile_pkg::ptw_req_t p;
    t   = 0;
    r   = next_rand();
    r64 = {next_rand(), next_rand()};
    repeat (r[9:8]) @(negedge CLK);
    @(negedge CLK);
    while (!ptw_ready) begin
        t++;
        if (t > 200) timeout_fail("ptw_ready");
        @(negedge CLK);
    end
    p.valid = 1'b1;
    p.addr  = r64[39:0];
    p.data  = {next_rand(), next_rand()};
    p.cmd   = r[0] ? `TILE_CMD_AMO_OR : r[5:1];  // Half AMO-OR, rest any code
    p.size  = r[7:6];
    ptw_req = p;
    ptw_exp.push_back(p);
    ptws_sent++;
    @(negedge CLK);
    ptw_req.valid = 1'b0;
endtask

task automatic wait_idle();
    int t;
    t = 0;
    @(negedge CLK);
    while (!(fill_ready && ptw_ready && n_resp == ptws_sent && n_refill == fills_sent)) begin
        t++;
        if (t > 500) timeout_fail("traffic to drain");
        @(negedge CLK);
    end
endtask

`endif

/* tests/tb_tile_glue.sv */
`timescale 1ns/1ps
`include "tile_config.svh"

module tb_tile_glue;

    logic                   CLK = 1'b0;
    logic                   RST = 1'b0;
    tile_pkg::fill_req_t    fill_req = '0;
    logic                   fill_ready;
    tile_pkg::fill_resp_t   fill_resp;
    tile_pkg::l2_acquire_t  acquire;
    logic                   acquire_ready = 1'b0;
    tile_pkg::l2_grant_t    grant = '0;
    logic                   l2_hit = 1'b0;
    tile_pkg::ptw_req_t     ptw_req = '0;
    logic                   ptw_ready;
    tile_pkg::ptw_resp_t    ptw_resp;
    tile_pkg::dcache_req_t  dcache_req;
    logic                   dcache_ready = 1'b0;
    tile_pkg::dcache_rsp_t  dcache_rsp = '0;
    tile_pkg::apb_req_t     apb_req = '0;
    tile_pkg::apb_rsp_t     apb_rsp;

    // Model state
    logic [31:0]            rng_q = 32'h2b81;
    logic [31:0]            l2_r;
    logic [31:0]            dc_r;
    logic [33:0]            exp_blk = '0;       // Line of the current fill
    logic [127:0]           beat_q [$];         // Beats sent, not yet seen
    int                     l2_beat = 4;        // 4 means no line granting
    int                     resp_idx = 0;
    logic                   line_hit = 1'b0;
    tile_pkg::ptw_req_t     ptw_exp [$];
    tile_pkg::ptw_req_t     exp_ptw;
    tile_pkg::dcache_req_t  held_req = '0;
    logic                   req_held = 1'b0;
    int                     dc_delay = 0;
    logic [63:0]            rdata_q [$];
    int                     fills_sent = 0;
    int                     ptws_sent = 0;
    int                     n_refill = 0;
    int                     n_hit = 0;
    int                     n_req = 0;
    int                     n_amo = 0;
    int                     n_resp = 0;

    always #4 CLK = ~CLK;                       // 8 ns period

    tile_glue_top dut (
        .CLK             (CLK),
        .RST             (RST),
        .fill_req_i      (fill_req),
        .fill_ready_o    (fill_ready),
        .fill_resp_o     (fill_resp),
        .acquire_o       (acquire),
        .acquire_ready_i (acquire_ready),
        .grant_i         (grant),
        .l2_hit_i        (l2_hit),
        .ptw_req_i       (ptw_req),
        .ptw_ready_o     (ptw_ready),
        .ptw_resp_o      (ptw_resp),
        .dcache_req_o    (dcache_req),
        .dcache_ready_i  (dcache_ready),
        .dcache_rsp_i    (dcache_rsp),
        .apb_i           (apb_req),
        .apb_o           (apb_rsp)
    );

`include "tb_tile_glue_tasks.svh"

    // ------------------------------------------------------------------------
    // L2 responder and fill response monitor
    // ------------------------------------------------------------------------
    always @(negedge CLK) begin
        if (fill_resp.valid) begin
            check_eq(128'(beat_q.size() != 0), 128'(1), "fill response without beat");
            check_eq(128'(fill_resp.beat), 128'(resp_idx), "fill response beat");
            check_eq(128'(fill_resp.data), beat_q.pop_front(), "fill response data");
            check_eq(128'(fill_resp.ack), 128'(resp_idx == 3), "fill ack");
            if (resp_idx == 3) begin
                n_refill++;
                if (line_hit) n_hit++;
            end
            resp_idx = (resp_idx + 1) % 4;
        end
        grant         = '0;
        l2_hit        = 1'b0;
        acquire_ready = 1'b0;
        if (RST) begin
            l2_r = next_rand();
            if (acquire.valid) begin
                check_eq(128'(acquire.block_addr), 128'(exp_blk), "acquire block address");
                acquire_ready = l2_r[1:0] != 2'b00;
                if (acquire_ready) l2_beat = 0;
            end else if (l2_beat < 4 && l2_r[3:2] != 2'b00) begin
                grant.valid = 1'b1;
                grant.beat  = 2'(l2_beat);
                grant.data  = {next_rand(), next_rand(), next_rand(), next_rand()};
                l2_hit      = l2_r[4];          // Only counts with the last beat
                beat_q.push_back(grant.data);
                if (l2_beat == 3) line_hit = l2_r[4];
                l2_beat++;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Data cache responder and walker response monitor
    // ------------------------------------------------------------------------
    always @(negedge CLK) begin
        if (ptw_resp.valid) begin
            check_eq(128'(rdata_q.size() != 0), 128'(1), "walker response without request");
            check_eq(128'(ptw_resp.data), 128'(rdata_q.pop_front()), "walker response data");
            n_resp++;
        end
        dcache_ready = 1'b0;
        dcache_rsp   = '0;
        if (RST) begin
            dc_r = next_rand();
            if (dc_delay > 0) begin
                dc_delay--;
                if (dc_delay == 0) begin
                    dcache_rsp.valid = 1'b1;
                    dcache_rsp.rdata = {next_rand(), next_rand()};
                    rdata_q.push_back(dcache_rsp.rdata);
                end
            end else if (dcache_req.valid) begin
                check_eq(128'(ptw_ready), 128'(0), "ptw_ready with request pending");
                if (!req_held) begin
                    check_eq(128'(ptw_exp.size() != 0), 128'(1), "cache request without walker");
                    exp_ptw        = ptw_exp.pop_front();
                    held_req.valid = 1'b1;
                    held_req.addr  = exp_ptw.addr;
                    held_req.wdata = exp_ptw.data;
                    held_req.size  = exp_ptw.size;
                    if (exp_ptw.cmd == `TILE_CMD_AMO_OR) begin
                        held_req.op = tile_pkg::DCACHE_AMO_OR;
                        held_req.be = 8'hff;
                    end else begin
                        held_req.op = tile_pkg::DCACHE_LOAD;
                        held_req.be = 8'h00;
                    end
                end
                // Same expected value each cycle, so a drift under back-pressure fails
                check_eq(128'(dcache_req), 128'(held_req), "cache request");
                req_held     = 1'b1;
                dcache_ready = dc_r[1:0] != 2'b00;
                if (dcache_ready) begin
                    req_held = 1'b0;
                    n_req++;
                    if (held_req.op == tile_pkg::DCACHE_AMO_OR) n_amo++;
                    dc_delay = 1 + int'(dc_r[3:2]);
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        logic [31:0] rd;
        logic [31:0] cyc0;
        logic [31:0] wval;
        logic        err;
        repeat (2) @(negedge CLK);
        RST = 1'b1;
        check_eq(128'({fill_ready, ptw_ready}), 128'(2'b11), "ready after reset");
        check_eq(128'({fill_resp.valid, acquire.valid}), 128'(0), "bridge valid after reset");
        check_eq(128'({ptw_resp.valid, dcache_req.valid}), 128'(0), "walker valid after reset");

        fork
            repeat (40) issue_fill();
            repeat (60) issue_ptw();
        join
        wait_idle();

        // Event counts against the model
        read_counter(`TILE_HPM_REFILL, n_refill, "refill counter");
        read_counter(`TILE_HPM_L2HIT, n_hit, "L2 hit counter");
        read_counter(`TILE_HPM_PTW_REQ, n_req, "walker request counter");
        read_counter(`TILE_HPM_PTW_AMO, n_amo, "walker AMO counter");
        apb_xfer(1'b0, 8'h00, 32'd0, cyc0, err);
        apb_xfer(1'b0, 8'h00, 32'd0, rd, err);
        check_eq(128'(rd > cyc0), 128'(1), "cycle counter advances");

        // Half writes, no events running
        wval = next_rand();
        apb_xfer(1'b1, 8'h08, wval, rd, err);
        apb_xfer(1'b0, 8'h08, 32'd0, rd, err);
        check_eq(128'({err, rd}), 128'({1'b0, wval}), "counter 1 low half write");
        wval = next_rand();
        apb_xfer(1'b1, 8'h24, wval, rd, err);
        apb_xfer(1'b0, 8'h24, 32'd0, rd, err);
        check_eq(128'({err, rd}), 128'({1'b0, wval}), "counter 4 high half write");

        // Bad addresses
        apb_xfer(1'b0, 8'h28, 32'd0, rd, err);
        check_eq(128'({err, rd}), 128'({1'b1, 32'd0}), "out of range read");
        apb_xfer(1'b0, 8'h0e, 32'd0, rd, err);
        check_eq(128'({err, rd}), 128'({1'b1, 32'd0}), "misaligned read");

        check_eq(128'(beat_q.size() + ptw_exp.size()), 128'(0), "leftover expected items");
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+src
+incdir+tests
src/tile_pkg.sv
src/l2_refill_bridge.sv
src/ptw_dmem_adapter.sv
src/hpm_counters.sv
src/tile_glue_top.sv
tests/tb_tile_glue.sv
